/* project.f */
verilog/edge_geom_pkg.sv
verilog/apb_pkg.sv
verilog/edge_fetch_if.sv
verilog/chunk_planner.sv
verilog/edge_array_reader.sv
verilog/edge_joiner.sv
verilog/edge_fetch_top.sv
sim/apb_mem_model.sv
sim/tb_edge_fetch.sv

/* run.sh */
#!/bin/sh
# Compile and run the edge fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_edge_fetch -f project.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_edge_fetch)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Done: no errors"; then
	exit 0
fi
exit 1

/* sim/apb_mem_model.sv */
//////////////////////////////////////////////////////////////////////
// APB slave memory model for one array port
// Read data is the address XOR a key, wait states are pseudo-random
// Protocol checks on the master side of the port
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module apb_mem_model import apb_pkg::*; #(
	parameter logic [31:0] KEY  = 32'h0,
	parameter logic [31:0] SEED = 32'h5a5d_6e19,
	parameter string       PORT = "apb"
) (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      psel,
	input  logic                      penable,
	input  logic [31:0]               paddr,
	output logic                      pready,
	output logic [APB_DATA_WIDTH-1:0] prdata
);

	int          fault_count;
	int          wait_left;
	logic [31:0] rng;

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	initial begin
		fault_count = 0;
		wait_left   = 0;
		pready      = 1'b0;
		prdata      = '0;
		// Own wait pattern per port, from the common seed
		rng = SEED ^ KEY;
		forever begin
			@(posedge clock);
			#1;
			if (!rstn || pready) begin
				pready = 1'b0;
			end else if (psel && penable) begin
				if (wait_left == 0) begin
					prdata = paddr ^ KEY;
					pready = 1'b1;
				end else begin
					wait_left--;
				end
			end else if (psel) begin
				// Setup phase seen, 0 to 3 wait states for this access
				rng       = lcg_next(rng);
				wait_left = int'(rng[17:16]);
			end
		end
	end

	////////////////////////////////////////////////////////////////////
	// Master protocol
	////////////////////////////////////////////////////////////////////

	setup_to_access: assert property (@(negedge clock) disable iff (!rstn)
		psel && !penable |=> psel && penable && $stable(paddr))
	else begin
		fault_count++;
		$display("%0t: %s port did not enter access after one setup cycle", $time, PORT);
	end

	access_hold: assert property (@(negedge clock) disable iff (!rstn)
		psel && penable && !pready |=> psel && penable && $stable(paddr))
	else begin
		fault_count++;
		$display("%0t: %s port changed psel, penable or paddr before pready", $time, PORT);
	end

	access_end: assert property (@(negedge clock) disable iff (!rstn)
		penable && pready |=> !penable)
	else begin
		fault_count++;
		$display("%0t: %s port kept penable after the transfer completed", $time, PORT);
	end

	enable_needs_setup: assert property (@(negedge clock) disable iff (!rstn)
		!psel |=> !penable)
	else begin
		fault_count++;
		$display("%0t: %s port raised penable without a setup phase", $time, PORT);
	end

	enable_needs_sel: assert property (@(negedge clock) disable iff (!rstn)
		penable |-> psel)
	else begin
		fault_count++;
		$display("%0t: %s port drove penable with psel low", $time, PORT);
	end

endmodule

/* sim/tb_edge_fetch.sv */
//////////////////////////////////////////////////////////////////////
// Edge fetch unit testbench
// Clock, reset, vertex jobs, an edge sink with random stalls, and
// assertions against the expected edge and address sequences
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_edge_fetch import apb_pkg::*; ();

	localparam int          ADDR_WIDTH  = 32;
	localparam int          INDEX_WIDTH = 24;
	localparam int          FIFO_DEPTH  = 8;
	localparam int          TIMEOUT     = 2000;
	localparam logic [31:0] SEED        = 32'h5a5d_6e19;
	localparam logic [31:0] SRC_BASE    = 32'h0004_0000;
	localparam logic [31:0] DEST_BASE   = 32'h0009_1200;
	localparam logic [31:0] SRC_KEY     = 32'hc3a5_0f0f;
	localparam logic [31:0] DEST_KEY    = 32'h3c5a_f0f0;

	logic                      clock;
	logic                      rstn;
	logic                      job_valid;
	logic                      job_ready;
	logic [INDEX_WIDTH-1:0]    job_first_index;
	logic [INDEX_WIDTH-1:0]    job_degree;
	logic                      src_psel;
	logic                      src_penable;
	logic [ADDR_WIDTH-1:0]     src_paddr;
	logic                      src_pready;
	logic [APB_DATA_WIDTH-1:0] src_prdata;
	logic                      dest_psel;
	logic                      dest_penable;
	logic [ADDR_WIDTH-1:0]     dest_paddr;
	logic                      dest_pready;
	logic [APB_DATA_WIDTH-1:0] dest_prdata;
	logic                      edge_valid;
	logic                      edge_ready;
	logic [APB_DATA_WIDTH-1:0] edge_src;
	logic [APB_DATA_WIDTH-1:0] edge_dest;
	logic                      edge_last;

	// Expected index sequence over all jobs, one read pointer per stream
	logic [INDEX_WIDTH-1:0] exp_index [$];
	bit                     exp_last [$];
	int                     src_ptr;
	int                     dest_ptr;
	int                     edge_ptr;
	logic                   job_fire;
	logic                   src_fire;
	logic                   dest_fire;
	logic                   edge_fire;
	logic                   edge_ok;
	logic                   src_addr_ok;
	logic                   dest_addr_ok;
	logic [31:0]            head_src;
	logic [31:0]            head_dest;
	logic                   head_last;
	logic [31:0]            src_addr_exp;
	logic [31:0]            dest_addr_exp;
	logic                   stall_all;
	logic                   jobs_started;
	logic [31:0]            rng;
	int                     mismatch_count;
	int                     fault_count;

	edge_fetch_top #(
		.ADDR_WIDTH  (ADDR_WIDTH),
		.INDEX_WIDTH (INDEX_WIDTH),
		.FIFO_DEPTH  (FIFO_DEPTH)
	) DUT (
		.clock           (clock),
		.rstn            (rstn),
		.job_valid       (job_valid),
		.job_ready       (job_ready),
		.job_first_index (job_first_index),
		.job_degree      (job_degree),
		.src_base        (SRC_BASE),
		.dest_base       (DEST_BASE),
		.src_psel        (src_psel),
		.src_penable     (src_penable),
		.src_paddr       (src_paddr),
		.src_pready      (src_pready),
		.src_prdata      (src_prdata),
		.dest_psel       (dest_psel),
		.dest_penable    (dest_penable),
		.dest_paddr      (dest_paddr),
		.dest_pready     (dest_pready),
		.dest_prdata     (dest_prdata),
		.edge_valid      (edge_valid),
		.edge_ready      (edge_ready),
		.edge_src        (edge_src),
		.edge_dest       (edge_dest),
		.edge_last       (edge_last)
	);

	apb_mem_model #(.KEY(SRC_KEY), .SEED(SEED), .PORT("source")) u_src_mem (
		.clock   (clock),
		.rstn    (rstn),
		.psel    (src_psel),
		.penable (src_penable),
		.paddr   (src_paddr),
		.pready  (src_pready),
		.prdata  (src_prdata)
	);

	apb_mem_model #(.KEY(DEST_KEY), .SEED(SEED), .PORT("destination")) u_dest_mem (
		.clock   (clock),
		.rstn    (rstn),
		.psel    (dest_psel),
		.penable (dest_penable),
		.paddr   (dest_paddr),
		.pready  (dest_pready),
		.prdata  (dest_prdata)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Array entry i sits at base plus 4 times i
	function automatic logic [31:0] addr_at(input logic [31:0] base,
			input logic [INDEX_WIDTH-1:0] index);
		return base + 32'(index) * 32'd4;
	endfunction

	task automatic send_job(input logic [INDEX_WIDTH-1:0] first,
			input logic [INDEX_WIDTH-1:0] degree);
		int waited;
		waited          = 0;
		job_first_index = first;
		job_degree      = degree;
		job_valid       = 1'b1;
		jobs_started    = 1'b1;
		while (!job_ready && waited < TIMEOUT) begin
			@(posedge clock);
			#1;
			waited++;
		end
		if (!job_ready) begin
			fault_count++;
			$display("%0t: timeout waiting for job_ready, job at %0d dropped", $time, first);
		end else begin
			@(posedge clock);
			#1;
		end
		job_valid = 1'b0;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while ((edge_ptr < exp_index.size() || src_ptr < exp_index.size() ||
				dest_ptr < exp_index.size()) && waited < TIMEOUT) begin
			@(posedge clock);
			#1;
			waited++;
		end
		if (edge_ptr < exp_index.size()) begin
			fault_count++;
			$display("%0t: timeout with %0d of %0d edges received", $time, edge_ptr,
				exp_index.size());
		end
	endtask

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// Edge sink, randomly stalled
	initial begin
		edge_ready = 1'b0;
		rng        = SEED;
		forever begin
			@(posedge clock);
			#1;
			rng        = lcg_next(rng);
			edge_ready = !stall_all && (rng[17:16] != 2'b00);
		end
	end

	// Handshakes seen mid-cycle complete on the next rising edge
	always @(negedge clock) begin
		job_fire  = rstn && job_valid && job_ready;
		src_fire  = rstn && src_psel && src_penable && src_pready;
		dest_fire = rstn && dest_psel && dest_penable && dest_pready;
		edge_fire = rstn && edge_valid && edge_ready;
	end

	always @(posedge clock) begin
		if (job_fire) begin
			for (int k = 0; k < int'(job_degree); k++) begin
				exp_index.push_back(job_first_index + INDEX_WIDTH'(k));
				exp_last.push_back(k == int'(job_degree) - 1);
			end
		end
		if (src_fire)
			src_ptr++;
		if (dest_fire)
			dest_ptr++;
		if (edge_fire)
			edge_ptr++;
		edge_ok      = edge_ptr < exp_index.size();
		src_addr_ok  = src_ptr < exp_index.size();
		dest_addr_ok = dest_ptr < exp_index.size();
		if (edge_ok) begin
			head_src  = addr_at(SRC_BASE, exp_index[edge_ptr]) ^ SRC_KEY;
			head_dest = addr_at(DEST_BASE, exp_index[edge_ptr]) ^ DEST_KEY;
			head_last = exp_last[edge_ptr];
		end
		if (src_addr_ok)
			src_addr_exp = addr_at(SRC_BASE, exp_index[src_ptr]);
		if (dest_addr_ok)
			dest_addr_exp = addr_at(DEST_BASE, exp_index[dest_ptr]);
	end

	////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////

	reset_state: assert property (@(negedge clock) disable iff (!rstn)
		!jobs_started |-> !src_psel && !src_penable && !dest_psel && !dest_penable &&
			!edge_valid && job_ready)
	else begin
		fault_count++;
		$display("%0t: outputs not in their idle state after reset", $time);
	end

	edge_expected: assert property (@(negedge clock) disable iff (!rstn)
		edge_valid && edge_ready |-> edge_ok)
	else begin
		fault_count++;
		$display("%0t: edge delivered beyond the expected edge count", $time);
	end

	edge_value: assert property (@(negedge clock) disable iff (!rstn)
		edge_valid && edge_ready && edge_ok |->
			edge_src == head_src && edge_dest == head_dest && edge_last == head_last)
	else begin
		mismatch_count++;
		$display("MISMATCH %0t: edge %0d is %h %h %b, expected %h %h %b", $time, edge_ptr,
			edge_src, edge_dest, edge_last, head_src, head_dest, head_last);
	end

	// Stalled edge must wait unchanged
	edge_hold: assert property (@(negedge clock) disable iff (!rstn)
		edge_valid && !edge_ready |=> edge_valid && $stable(edge_src) &&
			$stable(edge_dest) && $stable(edge_last))
	else begin
		fault_count++;
		$display("%0t: edge output changed while edge_ready was low", $time);
	end

	src_order: assert property (@(negedge clock) disable iff (!rstn)
		src_psel && src_penable && src_pready |-> src_addr_ok && src_paddr == src_addr_exp)
	else begin
		mismatch_count++;
		$display("MISMATCH %0t: source read %0d at %h, expected %h", $time, src_ptr,
			src_paddr, src_addr_exp);
	end

	dest_order: assert property (@(negedge clock) disable iff (!rstn)
		dest_psel && dest_penable && dest_pready |-> dest_addr_ok && dest_paddr == dest_addr_exp)
	else begin
		mismatch_count++;
		$display("MISMATCH %0t: destination read %0d at %h, expected %h", $time, dest_ptr,
			dest_paddr, dest_addr_exp);
	end

	////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////

	initial begin
		int other_count;
		rstn            = 1'b1;
		job_valid       = 1'b0;
		job_first_index = '0;
		job_degree      = '0;
		stall_all       = 1'b0;
		jobs_started    = 1'b0;
		mismatch_count  = 0;
		fault_count     = 0;
		src_ptr         = 0;
		dest_ptr        = 0;
		edge_ptr        = 0;
		job_fire        = 1'b0;
		src_fire        = 1'b0;
		dest_fire       = 1'b0;
		edge_fire       = 1'b0;
		edge_ok         = 1'b0;
		src_addr_ok     = 1'b0;
		dest_addr_ok    = 1'b0;
		#1 rstn = 1'b0;
		repeat (16) @(posedge clock);
		#1 rstn = 1'b1;
		// A few idle cycles for the reset state check
		repeat (4) @(posedge clock);
		#1;

		// Aligned line, misaligned start over three lines, single edge,
		// empty job, then a short job straight after it
		send_job(24'd32, 24'd16);
		send_job(24'd13, 24'd20);
		send_job(24'd7, 24'd1);
		send_job(24'd40, 24'd0);
		send_job(24'd50, 24'd5);

		// Long job with the sink stopped until the edge FIFO is full
		send_job(24'd100, 24'd40);
		stall_all = 1'b1;
		repeat (100) @(posedge clock);
		#1 stall_all = 1'b0;

		wait_drain();
		repeat (8) @(posedge clock);
		#1;

		other_count = fault_count + u_src_mem.fault_count + u_dest_mem.fault_count;
		$display("Checks finished with %0d mismatches and %0d other errors",
			mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

/* verilog/apb_pkg.sv */
//////////////////////////////////////////////////////////////////////
// APB data width and transfer phase encodings
//////////////////////////////////////////////////////////////////////

package apb_pkg;

	// PRDATA width, also the width of one edge word
	localparam int APB_DATA_WIDTH = 32;

	// Transfer phases of a master port
	localparam logic [1:0] APB_PHASE_IDLE   = 2'd0;
	localparam logic [1:0] APB_PHASE_SETUP  = 2'd1;
	localparam logic [1:0] APB_PHASE_ACCESS = 2'd2;

endpackage

/* verilog/chunk_planner.sv */
//////////////////////////////////////////////////////////////////////
// Vertex job planner
// Splits the edge range of a job into chunks that stay inside one
// cacheline and offers each chunk to both array readers at once
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module chunk_planner import edge_geom_pkg::*; #(
	parameter int INDEX_WIDTH = 24
) (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   job_valid,
	output logic                   job_ready,
	input  logic [INDEX_WIDTH-1:0] job_first_index,
	input  logic [INDEX_WIDTH-1:0] job_degree,
	chunk_if.planner               src_chunk,
	chunk_if.planner               dest_chunk
);

	localparam int LINE_BITS = $clog2(CACHELINE_EDGES);

	localparam logic [1:0] PLAN_IDLE  = 2'd0;
	localparam logic [1:0] PLAN_SIZE  = 2'd1;
	localparam logic [1:0] PLAN_OFFER = 2'd2;

	logic [1:0]             state;
	logic [INDEX_WIDTH-1:0] next_index;
	logic [INDEX_WIDTH-1:0] left;
	logic [INDEX_WIDTH-1:0] line_room;
	logic [INDEX_WIDTH-1:0] chunk_len;
	logic [INDEX_WIDTH-1:0] chunk_first;
	logic [INDEX_WIDTH-1:0] chunk_count;
	logic                   chunk_final;
	logic                   chunk_offer;
	logic                   job_take;
	logic                   chunk_take;

	assign job_ready = (state == PLAN_IDLE);
	assign job_take  = job_valid & job_ready;

	// Edges left before the next line boundary, short on a misaligned start
	assign line_room = INDEX_WIDTH'(CACHELINE_EDGES) - INDEX_WIDTH'(next_index[LINE_BITS-1:0]);
	assign chunk_len = (left < line_room) ? left : line_room;

	// Chunk stays on offer until both readers are ready
	assign chunk_offer = (state == PLAN_OFFER);

	// Both readers take the chunk in the same cycle or neither does
	assign chunk_take = chunk_offer & src_chunk.ready & dest_chunk.ready;

	assign src_chunk.valid        = chunk_offer;
	assign src_chunk.first_index  = chunk_first;
	assign src_chunk.count        = chunk_count;
	assign src_chunk.final_chunk  = chunk_final;
	assign dest_chunk.valid       = chunk_offer;
	assign dest_chunk.first_index = chunk_first;
	assign dest_chunk.count       = chunk_count;
	assign dest_chunk.final_chunk = chunk_final;

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			state <= PLAN_IDLE;
		end else begin
			case (state)
				PLAN_IDLE: begin
					// Zero degree jobs are swallowed here
					if (job_take && job_degree != '0)
						state <= PLAN_SIZE;
				end
				PLAN_SIZE: state <= PLAN_OFFER;
				PLAN_OFFER: begin
					if (chunk_take)
						state <= chunk_final ? PLAN_IDLE : PLAN_SIZE;
				end
				default: state <= PLAN_IDLE;
			endcase
		end
	end

	// Job progress and the chunk on offer
	always_ff @(posedge clock) begin
		if (job_take) begin
			next_index <= job_first_index;
			left       <= job_degree;
		end
		if (state == PLAN_SIZE) begin
			chunk_first <= next_index;
			chunk_count <= chunk_len;
			chunk_final <= (left == chunk_len);
			next_index  <= next_index + chunk_len;
			left        <= left - chunk_len;
		end
	end

endmodule

/* verilog/edge_array_reader.sv */
//////////////////////////////////////////////////////////////////////
// Edge array reader
// APB master that reads the words of one chunk, one per transfer,
// and streams them out with the job end marked
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module edge_array_reader import edge_geom_pkg::*, apb_pkg::*; #(
	parameter int ADDR_WIDTH  = 32,
	parameter int INDEX_WIDTH = 24
) (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic [ADDR_WIDTH-1:0]     array_base,
	chunk_if.reader                   chunk,
	output logic                      psel,
	output logic                      penable,
	output logic [ADDR_WIDTH-1:0]     paddr,
	input  logic                      pready,
	input  logic [APB_DATA_WIDTH-1:0] prdata,
	word_if.source                    words
);

	logic [1:0]                phase;
	logic                      busy;
	logic [INDEX_WIDTH-1:0]    index;
	logic [INDEX_WIDTH-1:0]    left;
	logic                      chunk_final;
	logic                      word_valid;
	logic                      word_last;
	logic [APB_DATA_WIDTH-1:0] word_data;
	logic                      chunk_take;
	logic                      read_done;
	logic                      word_take;

	assign chunk.ready = ~busy;
	assign chunk_take  = chunk.valid & ~busy;
	assign read_done   = (phase == APB_PHASE_ACCESS) & pready;
	assign word_take   = word_valid & words.ready;

	// Index only moves after completion, so the address holds per transfer
	assign paddr   = array_base + (ADDR_WIDTH'(index) << EDGE_SHIFT);
	assign psel    = (phase != APB_PHASE_IDLE);
	assign penable = (phase == APB_PHASE_ACCESS);

	assign words.valid = word_valid;
	assign words.data  = word_data;
	assign words.last  = word_last;

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			phase      <= APB_PHASE_IDLE;
			busy       <= 1'b0;
			left       <= '0;
			word_valid <= 1'b0;
		end else begin
			if (chunk_take) begin
				busy  <= 1'b1;
				left  <= chunk.count;
				phase <= APB_PHASE_SETUP;
			end
			if (phase == APB_PHASE_SETUP)
				phase <= APB_PHASE_ACCESS;
			if (read_done) begin
				phase      <= APB_PHASE_IDLE;
				word_valid <= 1'b1;
				left       <= left - 1'b1;
			end
			// Next read waits until the held word is gone
			if (word_take) begin
				word_valid <= 1'b0;
				if (left == '0)
					busy <= 1'b0;
				else
					phase <= APB_PHASE_SETUP;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (chunk_take) begin
			index       <= chunk.first_index;
			chunk_final <= chunk.final_chunk;
		end
		if (read_done) begin
			word_data <= prdata;
			word_last <= chunk_final && (left == INDEX_WIDTH'(1));
			index     <= index + 1'b1;
		end
	end

endmodule

/* verilog/edge_fetch_if.sv */
//////////////////////////////////////////////////////////////////////
// chunk_if  chunk hand-off from planner to one array reader
// word_if   edge word stream from one array reader to the joiner
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

interface chunk_if #(
	parameter int INDEX_WIDTH = 24
) ();
	logic [INDEX_WIDTH-1:0] first_index;
	logic [INDEX_WIDTH-1:0] count;
	// Last chunk of a vertex job
	logic                   final_chunk;
	logic                   valid;
	logic                   ready;

	modport planner (output first_index, count, final_chunk, valid, input ready);
	modport reader (input first_index, count, final_chunk, valid, output ready);
endinterface

interface word_if import apb_pkg::*; ();
	logic [APB_DATA_WIDTH-1:0] data;
	// Last word of a final chunk
	logic                      last;
	logic                      valid;
	logic                      ready;

	modport source (output data, last, valid, input ready);
	modport sink (input data, last, valid, output ready);
endinterface

/* verilog/edge_fetch_top.sv */
//////////////////////////////////////////////////////////////////////
// Edge fetch unit top level
// Chunk planner, source and destination array readers, edge joiner
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module edge_fetch_top import apb_pkg::*; #(
	parameter int ADDR_WIDTH  = 32,
	parameter int INDEX_WIDTH = 24,
	parameter int FIFO_DEPTH  = 8
) (
	input  logic                      clock,
	input  logic                      rstn,
	// Vertex jobs
	input  logic                      job_valid,
	output logic                      job_ready,
	input  logic [INDEX_WIDTH-1:0]    job_first_index,
	input  logic [INDEX_WIDTH-1:0]    job_degree,
	// Array bases, stable while jobs run
	input  logic [ADDR_WIDTH-1:0]     src_base,
	input  logic [ADDR_WIDTH-1:0]     dest_base,
	// Source array APB port
	output logic                      src_psel,
	output logic                      src_penable,
	output logic [ADDR_WIDTH-1:0]     src_paddr,
	input  logic                      src_pready,
	input  logic [APB_DATA_WIDTH-1:0] src_prdata,
	// Destination array APB port
	output logic                      dest_psel,
	output logic                      dest_penable,
	output logic [ADDR_WIDTH-1:0]     dest_paddr,
	input  logic                      dest_pready,
	input  logic [APB_DATA_WIDTH-1:0] dest_prdata,
	// Edge stream
	output logic                      edge_valid,
	input  logic                      edge_ready,
	output logic [APB_DATA_WIDTH-1:0] edge_src,
	output logic [APB_DATA_WIDTH-1:0] edge_dest,
	output logic                      edge_last
);

	chunk_if #(.INDEX_WIDTH(INDEX_WIDTH)) src_chunk ();
	chunk_if #(.INDEX_WIDTH(INDEX_WIDTH)) dest_chunk ();
	word_if src_words ();
	word_if dest_words ();

	chunk_planner #(.INDEX_WIDTH(INDEX_WIDTH)) u_planner (
		.clock           (clock),
		.rstn            (rstn),
		.job_valid       (job_valid),
		.job_ready       (job_ready),
		.job_first_index (job_first_index),
		.job_degree      (job_degree),
		.src_chunk       (src_chunk.planner),
		.dest_chunk      (dest_chunk.planner)
	);

	edge_array_reader #(.ADDR_WIDTH(ADDR_WIDTH), .INDEX_WIDTH(INDEX_WIDTH)) u_src_reader (
		.clock      (clock),
		.rstn       (rstn),
		.array_base (src_base),
		.chunk      (src_chunk.reader),
		.psel       (src_psel),
		.penable    (src_penable),
		.paddr      (src_paddr),
		.pready     (src_pready),
		.prdata     (src_prdata),
		.words      (src_words.source)
	);

	edge_array_reader #(.ADDR_WIDTH(ADDR_WIDTH), .INDEX_WIDTH(INDEX_WIDTH)) u_dest_reader (
		.clock      (clock),
		.rstn       (rstn),
		.array_base (dest_base),
		.chunk      (dest_chunk.reader),
		.psel       (dest_psel),
		.penable    (dest_penable),
		.paddr      (dest_paddr),
		.pready     (dest_pready),
		.prdata     (dest_prdata),
		.words      (dest_words.source)
	);

	edge_joiner #(.FIFO_DEPTH(FIFO_DEPTH)) u_joiner (
		.clock      (clock),
		.rstn       (rstn),
		.src_words  (src_words.sink),
		.dest_words (dest_words.sink),
		.edge_valid (edge_valid),
		.edge_ready (edge_ready),
		.edge_src   (edge_src),
		.edge_dest  (edge_dest),
		.edge_last  (edge_last)
	);

endmodule

/* verilog/edge_geom_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Edge array geometry shared by the chunk planner and array readers
// Edge word size, cacheline size and the values derived from them
//////////////////////////////////////////////////////////////////////

package edge_geom_pkg;

	// One edge word per array entry
	localparam int EDGE_BYTES = 4;

	// Memory line that a chunk must never cross
	localparam int CACHELINE_BYTES = 64;

	// Edges held by one cacheline
	localparam int CACHELINE_EDGES = CACHELINE_BYTES / EDGE_BYTES;

	// Index to byte offset
	localparam int EDGE_SHIFT = $clog2(EDGE_BYTES);

endpackage

/* verilog/edge_joiner.sv */
//////////////////////////////////////////////////////////////////////
// Edge joiner
// Pairs source and destination words into edges and queues them in
// the edge FIFO that feeds the output port
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module edge_joiner import apb_pkg::*; #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic                      clock,
	input  logic                      rstn,
	word_if.sink                      src_words,
	word_if.sink                      dest_words,
	output logic                      edge_valid,
	input  logic                      edge_ready,
	output logic [APB_DATA_WIDTH-1:0] edge_src,
	output logic [APB_DATA_WIDTH-1:0] edge_dest,
	output logic                      edge_last
);

	localparam int PTR_BITS = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

	logic [APB_DATA_WIDTH-1:0] src_mem  [FIFO_DEPTH];
	logic [APB_DATA_WIDTH-1:0] dest_mem [FIFO_DEPTH];
	logic                      last_mem [FIFO_DEPTH];
	logic [PTR_BITS-1:0]       wr_ptr;
	logic [PTR_BITS-1:0]       rd_ptr;
	logic [PTR_BITS:0]         fill;
	logic                      full;
	logic                      push;
	logic                      pop;

	assign full = (fill == (PTR_BITS+1)'(FIFO_DEPTH));

	// A pair moves only as a whole, so neither stream can run ahead
	assign push             = src_words.valid & dest_words.valid & ~full;
	assign src_words.ready  = push;
	assign dest_words.ready = push;

	assign edge_valid = (fill != '0);
	assign pop        = edge_valid & edge_ready;
	assign edge_src   = src_mem[rd_ptr];
	assign edge_dest  = dest_mem[rd_ptr];
	assign edge_last  = last_mem[rd_ptr];

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_BITS'(FIFO_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_BITS'(FIFO_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
			if (push && !pop)
				fill <= fill + 1'b1;
			else if (pop && !push)
				fill <= fill - 1'b1;
		end
	end

	// Job end comes from the source stream
	always_ff @(posedge clock) begin
		if (push) begin
			src_mem[wr_ptr]  <= src_words.data;
			dest_mem[wr_ptr] <= dest_words.data;
			last_mem[wr_ptr] <= src_words.last;
		end
	end

endmodule
